/* rtl/hmr_consts.svh */
/*
 * Shared constants for the lockstep subsystem.
 * Datapath width, register port widths, register offsets
 * and the read value for unmapped register addresses.
 */

`ifndef HMR_CONSTS_SVH
`define HMR_CONSTS_SVH

// Accumulator and operand width
`define DATA_W 16

// Register port widths
`define REG_AW 4
`define REG_DW 32

// Register offsets
`define REG_MODE_OFS   4'h0
`define REG_ERRCNT_OFS 4'h4
`define REG_STATUS_OFS 4'h8

// Returned on reads of unmapped addresses
`define REG_ERR_VAL 32'hBADCAB1E

`endif

/* rtl/core_pkg.sv */
/*
 * Core-side types.
 * Accumulator opcodes and the core output state.
 */

package core_pkg;

  // Opcodes of the accumulator core
  typedef enum logic [1:0] {
    // acc = operand
    OP_LOAD = 2'd0,
    // acc = acc + operand
    OP_ADD  = 2'd1,
    // acc = acc - operand
    OP_SUB  = 2'd2,
    // acc = acc ^ operand
    OP_XOR  = 2'd3
  } core_op_e;

  // Output state, EMIT lasts one cycle per command
  typedef enum logic {
    CORE_IDLE = 1'b0,
    CORE_EMIT = 1'b1
  } core_state_e;

endpackage

/* rtl/hmr_pkg.sv */
/*
 * Redundancy unit types.
 * Operating mode and the register map.
 */

`include "hmr_consts.svh"

package hmr_pkg;

  // Mode register bit 0
  typedef enum logic {
    MODE_INDEP = 1'b0,
    MODE_DMR   = 1'b1
  } hmr_mode_e;

  // Mapped register offsets
  typedef enum logic [`REG_AW-1:0] {
    REG_MODE   = `REG_MODE_OFS,
    REG_ERRCNT = `REG_ERRCNT_OFS,
    REG_STATUS = `REG_STATUS_OFS
  } reg_addr_e;

endpackage

/* rtl/acc_core.sv */
/*
 * Accumulator core standing in for a processor hart.
 * One command per valid strobe, one write result a cycle later.
 * Clear zeroes the accumulator and drops a pending result.
 */

`timescale 1ns/1ps

`include "hmr_consts.svh"

module acc_core (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   clear_i,
  input  logic                   cmd_valid_i,
  input  core_pkg::core_op_e     cmd_op_i,
  input  logic [`DATA_W-1:0]     cmd_data_i,
  output logic                   wr_valid_o,
  output logic [`DATA_W-1:0]     wr_data_o
);

  core_pkg::core_state_e state_q;
  core_pkg::core_state_e state_d;
  logic [`DATA_W-1:0]    acc_q;
  logic [`DATA_W-1:0]    acc_d;
  logic [`DATA_W-1:0]    acc_new;

  // Opcode evaluation, wraps modulo 2^DATA_W
  always_comb begin
    case (cmd_op_i)
      core_pkg::OP_LOAD: acc_new = cmd_data_i;
      core_pkg::OP_ADD:  acc_new = acc_q + cmd_data_i;
      core_pkg::OP_SUB:  acc_new = acc_q - cmd_data_i;
      core_pkg::OP_XOR:  acc_new = acc_q ^ cmd_data_i;
      default:           acc_new = acc_q;
    endcase
  end

  // Next state, clear wins over a command at the same edge
  always_comb begin
    acc_d   = acc_q;
    state_d = core_pkg::CORE_IDLE;
    if (clear_i) begin
      acc_d   = '0;
      state_d = core_pkg::CORE_IDLE;
    end else if (cmd_valid_i) begin
      acc_d   = acc_new;
      state_d = core_pkg::CORE_EMIT;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= core_pkg::CORE_IDLE;
      acc_q   <= '0;
    end else begin
      state_q <= state_d;
      acc_q   <= acc_d;
    end
  end

  // Result is the freshly updated accumulator
  assign wr_valid_o = (state_q == core_pkg::CORE_EMIT);
  assign wr_data_o  = acc_q;

endmodule

/* rtl/dmr_unit.sv */
/*
 * Dual modular redundancy unit for two harts.
 * Input fan-out and output compare in lockstep mode,
 * setback generation, saturating error counter and register port.
 */

`timescale 1ns/1ps

`include "hmr_consts.svh"

module dmr_unit (
  input  logic                          clk_i,
  input  logic                          arst_n_i,

  // System side, one entry per hart
  input  logic [1:0]                    sys_cmd_valid_i,
  input  core_pkg::core_op_e [1:0]      sys_cmd_op_i,
  input  logic [1:0][`DATA_W-1:0]       sys_cmd_data_i,
  output logic [1:0]                    sys_wr_valid_o,
  output logic [1:0][`DATA_W-1:0]       sys_wr_data_o,

  // Register port
  input  logic                          reg_valid_i,
  input  logic                          reg_we_i,
  input  logic [`REG_AW-1:0]            reg_addr_i,
  input  logic [`REG_DW-1:0]            reg_wdata_i,
  output logic [`REG_DW-1:0]            reg_rdata_o,
  output logic                          reg_error_o,

  output logic                          dmr_error_o,

  // Core side, one entry per core
  output logic [1:0]                    core_cmd_valid_o,
  output core_pkg::core_op_e [1:0]      core_cmd_op_o,
  output logic [1:0][`DATA_W-1:0]       core_cmd_data_o,
  output logic [1:0]                    core_clear_o,
  input  logic [1:0]                    core_wr_valid_i,
  input  logic [1:0][`DATA_W-1:0]       core_wr_data_i
);

  hmr_pkg::hmr_mode_e mode_q;
  hmr_pkg::reg_addr_e reg_addr;
  logic [7:0]         errcnt_q;
  logic               setback_q;
  logic               lockstep;
  logic               mismatch;
  logic               reg_wr;

  assign lockstep = (mode_q == hmr_pkg::MODE_DMR);

  // Input steering, hart 0 feeds both cores in lockstep
  always_comb begin
    core_cmd_valid_o = sys_cmd_valid_i;
    core_cmd_op_o    = sys_cmd_op_i;
    core_cmd_data_o  = sys_cmd_data_i;
    if (lockstep) begin
      core_cmd_valid_o[1] = sys_cmd_valid_i[0];
      core_cmd_op_o[1]    = sys_cmd_op_i[0];
      core_cmd_data_o[1]  = sys_cmd_data_i[0];
    end
  end

  // Differing valids, or both valid with differing data
  always_comb begin
    mismatch = 1'b0;
    if (lockstep) begin
      if (core_wr_valid_i[0] != core_wr_valid_i[1]) begin
        mismatch = 1'b1;
      end else if (core_wr_valid_i[0] && (core_wr_data_i[0] != core_wr_data_i[1])) begin
        mismatch = 1'b1;
      end
    end
  end

  // Output side, hart 1 is silent while in lockstep
  always_comb begin
    sys_wr_valid_o = core_wr_valid_i;
    sys_wr_data_o  = core_wr_data_i;
    if (lockstep) begin
      sys_wr_valid_o[0] = core_wr_valid_i[0] & ~mismatch;
      sys_wr_valid_o[1] = 1'b0;
      sys_wr_data_o[1]  = '0;
    end
  end

  // One setback cycle follows each mismatch cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      setback_q <= 1'b0;
    end else begin
      setback_q <= mismatch;
    end
  end

  assign dmr_error_o  = setback_q;
  assign core_clear_o = {2{setback_q}};

  assign reg_addr = hmr_pkg::reg_addr_e'(reg_addr_i);
  assign reg_wr   = reg_valid_i & reg_we_i;

  // Mode register, used from the next edge on
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mode_q <= hmr_pkg::MODE_INDEP;
    end else if (reg_wr && (reg_addr == hmr_pkg::REG_MODE)) begin
      mode_q <= hmr_pkg::hmr_mode_e'(reg_wdata_i[0]);
    end
  end

  // Error counter, a software write clears it
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      errcnt_q <= '0;
    end else if (reg_wr && (reg_addr == hmr_pkg::REG_ERRCNT)) begin
      errcnt_q <= '0;
    end else if (mismatch && (errcnt_q != 8'hFF)) begin
      errcnt_q <= errcnt_q + 8'd1;
    end
  end

  // Read decode, same cycle as the strobe
  always_comb begin
    reg_rdata_o = '0;
    reg_error_o = 1'b0;
    case (reg_addr)
      hmr_pkg::REG_MODE: begin
        reg_rdata_o[0] = mode_q;
      end
      hmr_pkg::REG_ERRCNT: begin
        reg_rdata_o[7:0] = errcnt_q;
      end
      hmr_pkg::REG_STATUS: begin
        // Setback in progress
        reg_rdata_o[0] = setback_q;
      end
      default: begin
        reg_rdata_o = `REG_ERR_VAL;
        reg_error_o = reg_valid_i;
      end
    endcase
  end

endmodule

/* rtl/dmr_core_wrap.sv */
/*
 * Lockstep subsystem top level.
 * Two accumulator cores behind the redundancy unit.
 */

`timescale 1ns/1ps

`include "hmr_consts.svh"

module dmr_core_wrap (
  input  logic                          clk_i,
  input  logic                          arst_n_i,

  input  logic [1:0]                    cmd_valid_i,
  input  core_pkg::core_op_e [1:0]      cmd_op_i,
  input  logic [1:0][`DATA_W-1:0]       cmd_data_i,
  output logic [1:0]                    wr_valid_o,
  output logic [1:0][`DATA_W-1:0]       wr_data_o,

  input  logic                          reg_valid_i,
  input  logic                          reg_we_i,
  input  logic [`REG_AW-1:0]            reg_addr_i,
  input  logic [`REG_DW-1:0]            reg_wdata_i,
  output logic [`REG_DW-1:0]            reg_rdata_o,
  output logic                          reg_error_o,

  output logic                          dmr_error_o
);

  // Unit to core
  logic [1:0]                    core_cmd_valid;
  core_pkg::core_op_e [1:0]      core_cmd_op;
  logic [1:0][`DATA_W-1:0]       core_cmd_data;
  logic [1:0]                    core_clear;
  // Core to unit
  logic [1:0]                    core_wr_valid;
  logic [1:0][`DATA_W-1:0]       core_wr_data;

  dmr_unit i_dmr_unit (
    .clk_i            ( clk_i          ),
    .arst_n_i         ( arst_n_i       ),
    .sys_cmd_valid_i  ( cmd_valid_i    ),
    .sys_cmd_op_i     ( cmd_op_i       ),
    .sys_cmd_data_i   ( cmd_data_i     ),
    .sys_wr_valid_o   ( wr_valid_o     ),
    .sys_wr_data_o    ( wr_data_o      ),
    .reg_valid_i      ( reg_valid_i    ),
    .reg_we_i         ( reg_we_i       ),
    .reg_addr_i       ( reg_addr_i     ),
    .reg_wdata_i      ( reg_wdata_i    ),
    .reg_rdata_o      ( reg_rdata_o    ),
    .reg_error_o      ( reg_error_o    ),
    .dmr_error_o      ( dmr_error_o    ),
    .core_cmd_valid_o ( core_cmd_valid ),
    .core_cmd_op_o    ( core_cmd_op    ),
    .core_cmd_data_o  ( core_cmd_data  ),
    .core_clear_o     ( core_clear     ),
    .core_wr_valid_i  ( core_wr_valid  ),
    .core_wr_data_i   ( core_wr_data   )
  );

  for (genvar i = 0; i < 2; i++) begin : gen_cores
    acc_core i_core (
      .clk_i       ( clk_i             ),
      .arst_n_i    ( arst_n_i          ),
      .clear_i     ( core_clear[i]     ),
      .cmd_valid_i ( core_cmd_valid[i] ),
      .cmd_op_i    ( core_cmd_op[i]    ),
      .cmd_data_i  ( core_cmd_data[i]  ),
      .wr_valid_o  ( core_wr_valid[i]  ),
      .wr_data_o   ( core_wr_data[i]   )
    );
  end

endmodule

/* verification/dmr_checker.sv */
/*
 * Checker for the lockstep subsystem testbench.
 * Reference model of both accumulators, mode, setback and error counter.
 * Compares write pulses, error pulses and register reads every cycle.
 */

`timescale 1ns/1ps

`include "hmr_consts.svh"

module dmr_checker (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic [1:0]               cmd_valid_i,
  input  core_pkg::core_op_e [1:0] cmd_op_i,
  input  logic [1:0][`DATA_W-1:0]  cmd_data_i,
  input  logic [1:0]               wr_valid_i,
  input  logic [1:0][`DATA_W-1:0]  wr_data_i,
  input  logic                     reg_valid_i,
  input  logic                     reg_we_i,
  input  logic [`REG_AW-1:0]       reg_addr_i,
  input  logic [`REG_DW-1:0]       reg_wdata_i,
  input  logic [`REG_DW-1:0]       reg_rdata_i,
  input  logic                     reg_error_i,
  input  logic                     dmr_error_i,
  output int                       error_count_o
);

  logic [1:0][`DATA_W-1:0] acc;
  logic [1:0]              pend;
  logic                    setback;
  logic [7:0]              errcnt;
  hmr_pkg::hmr_mode_e      mode;

  initial begin
    error_count_o = 0;
  end

  task automatic compare_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns: %s expected %h, got %h", $time, what, expected, actual);
      error_count_o++;
    end
  endtask

  // Opcode rules, results wrap modulo 2^16
  function automatic logic [`DATA_W-1:0] apply_op(input core_pkg::core_op_e op,
                                                  input logic [`DATA_W-1:0] a,
                                                  input logic [`DATA_W-1:0] b);
    case (op)
      core_pkg::OP_LOAD: return b;
      core_pkg::OP_ADD:  return a + b;
      core_pkg::OP_SUB:  return a - b;
      default:           return a ^ b;
    endcase
  endfunction

  always @(posedge clk_i or negedge arst_n_i) begin : model_step
    logic                     lockstep;
    logic                     mismatch;
    logic [1:0]               exp_valid;
    logic [1:0]               step_valid;
    core_pkg::core_op_e [1:0] step_op;
    logic [1:0][`DATA_W-1:0]  step_data;
    logic [`REG_DW-1:0]       exp_rdata;
    logic                     exp_rerr;
    if (!arst_n_i) begin
      acc     = '0;
      pend    = '0;
      setback = 1'b0;
      errcnt  = '0;
      mode    = hmr_pkg::MODE_INDEP;
    end else begin
      // Outputs of the cycle that just ended
      lockstep  = (mode == hmr_pkg::MODE_DMR);
      mismatch  = lockstep && ((pend[0] != pend[1]) || (pend[0] && (acc[0] != acc[1])));
      exp_valid = lockstep ? {1'b0, pend[0] & ~mismatch} : pend;
      for (int h = 0; h < 2; h++) begin
        compare_value($sformatf("wr_valid_o[%0d]", h), exp_valid[h], wr_valid_i[h]);
        if (exp_valid[h]) begin
          compare_value($sformatf("wr_data_o[%0d]", h), acc[h], wr_data_i[h]);
        end else if (lockstep && h == 1) begin
          // Hart 1 held at zero in lockstep
          compare_value("wr_data_o[1]", '0, wr_data_i[1]);
        end
      end
      compare_value("dmr_error_o", setback, dmr_error_i);
      if (reg_valid_i) begin
        exp_rdata = '0;
        exp_rerr  = 1'b0;
        case (reg_addr_i)
          hmr_pkg::REG_MODE:   exp_rdata[0] = lockstep;
          hmr_pkg::REG_ERRCNT: exp_rdata[7:0] = errcnt;
          hmr_pkg::REG_STATUS: exp_rdata[0] = setback;
          default: begin
            exp_rdata = `REG_ERR_VAL;
            exp_rerr  = 1'b1;
          end
        endcase
        compare_value("reg_error_o", exp_rerr, reg_error_i);
        if (!reg_we_i) begin
          compare_value("reg_rdata_o", exp_rdata, reg_rdata_i);
        end
      end
      // Hart 0 feeds both cores in lockstep
      step_valid = cmd_valid_i;
      step_op    = cmd_op_i;
      step_data  = cmd_data_i;
      if (lockstep) begin
        step_valid[1] = cmd_valid_i[0];
        step_op[1]    = cmd_op_i[0];
        step_data[1]  = cmd_data_i[0];
      end
      for (int c = 0; c < 2; c++) begin
        if (setback) begin
          acc[c]  = '0;
          pend[c] = 1'b0;
        end else begin
          if (step_valid[c]) begin
            acc[c] = apply_op(step_op[c], acc[c], step_data[c]);
          end
          pend[c] = step_valid[c];
        end
      end
      setback = mismatch;
      if (reg_valid_i && reg_we_i && (reg_addr_i == hmr_pkg::REG_ERRCNT)) begin
        errcnt = '0;
      end else if (mismatch && (errcnt != 8'hFF)) begin
        errcnt = errcnt + 8'd1;
      end
      if (reg_valid_i && reg_we_i && (reg_addr_i == hmr_pkg::REG_MODE)) begin
        mode = hmr_pkg::hmr_mode_e'(reg_wdata_i[0]);
      end
    end
  end

endmodule

/* verification/tb_dmr_core_wrap.sv */
/*
 * Testbench for the lockstep subsystem.
 * Clock, reset, step file reader and stimulus driver.
 */

`timescale 1ns/1ps

`include "hmr_consts.svh"

module tb_dmr_core_wrap;

  logic                     clk_i;
  logic                     arst_n_i;
  logic [1:0]               cmd_valid_i;
  core_pkg::core_op_e [1:0] cmd_op_i;
  logic [1:0][`DATA_W-1:0]  cmd_data_i;
  logic [1:0]               wr_valid_o;
  logic [1:0][`DATA_W-1:0]  wr_data_o;
  logic                     reg_valid_i;
  logic                     reg_we_i;
  logic [`REG_AW-1:0]       reg_addr_i;
  logic [`REG_DW-1:0]       reg_wdata_i;
  logic [`REG_DW-1:0]       reg_rdata_o;
  logic                     reg_error_o;
  logic                     dmr_error_o;
  int                       error_count;

  int               fd;
  int               n_fields;
  int               step_no;
  int               n_pass;
  int               n_fail;
  int               errors_before;
  bit               aborted;
  string            name;
  logic [8*128-1:0] line_buf;
  logic [7:0]       kind;
  logic [31:0]      hart;
  logic [31:0]      sel;
  logic [31:0]      data;
  logic [31:0]      expected;

  dmr_core_wrap UUT (.*);

  dmr_checker i_checker (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .cmd_valid_i(cmd_valid_i), .cmd_op_i(cmd_op_i),
    .cmd_data_i(cmd_data_i), .wr_valid_i(wr_valid_o), .wr_data_i(wr_data_o),
    .reg_valid_i(reg_valid_i), .reg_we_i(reg_we_i), .reg_addr_i(reg_addr_i),
    .reg_wdata_i(reg_wdata_i), .reg_rdata_i(reg_rdata_o), .reg_error_i(reg_error_o),
    .dmr_error_i(dmr_error_o), .error_count_o(error_count)
  );

  initial begin
    clk_i = 1'b0;
  end

  always #20 clk_i = ~clk_i;

  task automatic drive_command(input logic [31:0] h, input logic [31:0] op,
                               input logic [31:0] operand);
    @(posedge clk_i);
    cmd_valid_i[h] <= 1'b1;
    cmd_op_i[h]    <= core_pkg::core_op_e'(op[1:0]);
    cmd_data_i[h]  <= operand[`DATA_W-1:0];
    @(posedge clk_i);
    cmd_valid_i[h] <= 1'b0;
  endtask

  // Read data is combinational, sampled mid-cycle
  task automatic access_register(input bit we, input logic [31:0] addr,
                                 input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk_i);
    reg_valid_i <= 1'b1;
    reg_we_i    <= we;
    reg_addr_i  <= addr[`REG_AW-1:0];
    reg_wdata_i <= wdata;
    @(negedge clk_i);
    rdata = reg_rdata_o;
    @(posedge clk_i);
    reg_valid_i <= 1'b0;
    reg_we_i    <= 1'b0;
  endtask

  task automatic await_pulse(input bit is_error, input logic [31:0] h, output bit seen);
    seen = 1'b0;
    for (int n = 0; n < 20 && !seen; n++) begin
      @(negedge clk_i);
      seen = is_error ? dmr_error_o : wr_valid_o[h];
    end
    if (!seen) begin
      $display("Timeout: %s never went high within 20 cycles",
               is_error ? "dmr_error_o" : $sformatf("wr_valid_o[%0d]", h));
      aborted = 1'b1;
    end
  endtask

  task automatic run_step();
    bit          seen;
    logic [31:0] rdata;
    case (kind)
      "C", "E": begin
        name = $sformatf("%s hart %0d op %0d data %h", kind == "C" ? "command" : "mismatch",
                         hart, sel, data);
        drive_command(hart, sel, data);
        await_pulse(kind == "E", hart, seen);
        if (seen && kind == "C") begin
          i_checker.compare_value("wr_data_o", expected, wr_data_o[hart]);
        end else if (seen) begin
          // Error pulse length in cycles
          @(negedge clk_i);
          i_checker.compare_value("dmr_error_o pulse cycles", expected,
                                  32'd1 + dmr_error_o);
        end
      end
      "W": begin
        name = $sformatf("write reg %h data %h", sel, data);
        access_register(1'b1, sel, data, rdata);
      end
      "R": begin
        name = $sformatf("read reg %h", sel);
        access_register(1'b0, sel, data, rdata);
        i_checker.compare_value("reg_rdata_o", expected, rdata);
      end
      default: begin
        $display("Unknown step kind in the test file");
        aborted = 1'b1;
      end
    endcase
  endtask

  initial begin
    cmd_valid_i = '0;
    cmd_data_i  = '0;
    for (int h = 0; h < 2; h++) begin
      cmd_op_i[h] = core_pkg::OP_LOAD;
    end
    reg_valid_i = 1'b0;
    reg_we_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    arst_n_i    = 1'b0;
    void'($urandom(32'hc449));
    step_no     = 0;
    n_pass      = 0;
    n_fail      = 0;
    aborted     = 1'b0;
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;
    // Outputs idle right after reset
    @(negedge clk_i);
    errors_before = error_count;
    i_checker.compare_value("outputs after reset", '0, {wr_valid_o, dmr_error_o, reg_error_o});
    if (error_count == errors_before) begin
      n_pass++;
      $display("Step 0 reset outputs: pass");
    end else begin
      n_fail++;
      $display("Step 0 reset outputs: fail");
    end
    fd = $fopen("verification/dmr_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open verification/dmr_tests.txt");
      aborted = 1'b1;
    end else begin
      while (!aborted && !$feof(fd)) begin
        line_buf = '0;
        n_fields = $fgets(line_buf, fd);
        n_fields = $sscanf(line_buf, "%s %h %h %h %h", kind, hart, sel, data, expected);
        if (n_fields == 5 && kind != "#") begin
          step_no++;
          errors_before = error_count;
          run_step();
          if (!aborted && error_count == errors_before) begin
            n_pass++;
            $display("Step %0d %s: pass", step_no, name);
          end else begin
            n_fail++;
            $display("Step %0d %s: fail", step_no, name);
          end
          // Idle gap does not change any expected value
          repeat ($urandom_range(3, 1)) @(posedge clk_i);
        end
      end
      $fclose(fd);
    end
    $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0 && !aborted && error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+rtl
rtl/core_pkg.sv
rtl/hmr_pkg.sv
rtl/acc_core.sv
rtl/dmr_unit.sv
rtl/dmr_core_wrap.sv
verification/dmr_checker.sv
verification/tb_dmr_core_wrap.sv

/* verification/dmr_tests.txt */
# kind hart op_or_addr data expected, all hex
# C command, E command that mismatches, W register write, R register read
R 0 0 0 0
R 0 4 0 0
R 0 8 0 0
C 0 0 1234 1234
C 1 0 00ff 00ff
C 0 1 0010 1244
C 1 2 0100 ffff
C 0 3 ffff edbb
C 1 1 0002 0001
C 0 0 5a5a 5a5a
C 1 0 5a5a 5a5a
W 0 0 1 0
R 0 0 0 1
C 0 1 0001 5a5b
C 0 2 005b 5a00
C 0 3 00ff 5aff
R 0 4 0 0
W 0 0 0 0
R 0 0 0 0
C 1 0 1111 1111
W 0 0 1 0
E 0 1 0001 1
C 0 1 0042 0042
R 0 4 0 1
W 0 0 0 0
C 1 3 00ff 00bd
W 0 0 1 0
E 0 2 0001 1
R 0 4 0 2
W 0 4 0 0
R 0 4 0 0
C 0 1 0007 0007
R 0 8 0 0
R 0 3 0 badcab1e
R 0 c 0 badcab1e
W 0 0 0 0
R 0 0 0 0
C 1 1 0003 000a
